// ==== src/FirTypesPkg.sv ====
package FirTypesPkg;

    // Fraction bits of coefficients and partial sums
    localparam int MantW = 14;
    // Accumulator with headroom for 32 taps
    localparam int AccW = 18;
    localparam int OutW = 14;

    typedef logic signed [AccW-1:0] acc_t;
    typedef logic [OutW-1:0] out_t;

    // One word moving through the adder tree
    typedef struct packed {
        acc_t sum;
        logic valid;
    } treeBeat_t;

    typedef enum logic {
        wsFilling,
        wsFull
    } fillState_e;

    // Tables needed to cover a window half
    function automatic int lutCount(input int bits, input int lutSize);
        return (bits + lutSize - 1) / lutSize;
    endfunction

endpackage

// ==== src/FirCoeffPkg.sv ====
package FirCoeffPkg;

    import FirTypesPkg::*;

    localparam int MaxTaps = 32;

    // Lookahead taps scaled by 2**MantW
    localparam acc_t hb [MaxTaps] = '{
        2400, 2210, 1985, 1730, 1460, 1190,  935,  705,
         508,  347,  221,  128,   63,   21,   -4,  -17,
         -22,  -23,  -20,  -16,  -12,   -9,   -6,   -3,
           2,    5,    7,    8,    9,   10,   11,   12
    };

    // Lookback taps with the same scaling
    localparam acc_t hf [MaxTaps] = '{
        2530, 2320, 2075, 1805, 1525, 1245,  980,  740,
         536,  366,  233,  135,   67,   24,   -8,  -19,
         -25,  -26,  -21,  -18,  -13,  -10,   -7,   -5,
           1,    3,    4,    6,   13,   14,   15,   16
    };

    // Tail taps are kept small so that the full sum stays inside acc_t
    // even with 32 taps on both sides. The first eight on each side
    // together exceed the output range, so saturation can occur with
    // the default window.

endpackage

// ==== src/SampleWindow.sv ====
`timescale 1ns/100ps

module SampleWindow import FirTypesPkg::*; #(
    parameter int Osr = 4,
    parameter int Lookahead = 8,
    parameter int Lookback = 8
) (
    input  logic                 clkDS,
    input  logic                 rst,
    input  logic [Osr-1:0]       frame,
    output logic [Lookahead-1:0] aheadBits,
    output logic [Lookback-1:0]  backBits,
    output logic                 windowFull
);

    localparam int Total = Lookahead + Lookback;
    localparam int FillFrames = (Total + Osr - 1) / Osr;
    localparam int CntW = $clog2(FillFrames + 1);

    logic [Total-1:0] window;
    logic [CntW-1:0]  frameCount;
    fillState_e       state;

    // Newest frame enters at index 0, oldest bits fall off the top
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            window <= '0;
        end else begin
            window <= Total'({window, frame});
        end
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            state <= wsFilling;
            frameCount <= '0;
        end else if (state == wsFilling) begin
            if (frameCount == CntW'(FillFrames - 1)) begin
                state <= wsFull;
            end else begin
                frameCount <= frameCount + 1'b1;
            end
        end
    end

    assign windowFull = (state == wsFull);

    // Lookahead half is read back to front
    for (genvar i = 0; i < Lookahead; i++) begin : genAhead
        assign aheadBits[i] = window[Lookahead-1-i];
    end

    assign backBits = window[Total-1:Lookahead];

endmodule

// ==== src/DaLut.sv ====
`timescale 1ns/100ps

module DaLut import FirTypesPkg::*; #(
    parameter int Size = 4,
    parameter acc_t [Size-1:0] Coeffs = '0
) (
    input  logic [Size-1:0] sel,
    output acc_t            result
);

    localparam int Entries = 2 ** Size;

    // Entry idx holds the sum of the taps whose bit is set in idx
    function automatic acc_t [Entries-1:0] buildTable();
        acc_t [Entries-1:0] tbl;
        acc_t sum;
        for (int idx = 0; idx < Entries; idx++) begin
            sum = '0;
            for (int b = 0; b < Size; b++) begin
                if (idx[b]) begin
                    sum = sum + acc_t'(Coeffs[b]);
                end
            end
            tbl[idx] = sum;
        end
        return tbl;
    endfunction

    localparam acc_t [Entries-1:0] SumTable = buildTable();

    assign result = SumTable[sel];

endmodule

// ==== src/LutBank.sv ====
`timescale 1ns/100ps

module LutBank import FirTypesPkg::*, FirCoeffPkg::*; #(
    parameter int Lookahead = 8,
    parameter int Lookback = 8,
    parameter int LutSize = 4,
    parameter int NumLuts = 4
) (
    input  logic [Lookahead-1:0] aheadBits,
    input  logic [Lookback-1:0]  backBits,
    output acc_t [NumLuts-1:0]   lutSums
);

    localparam int AheadLuts = lutCount(Lookahead, LutSize);
    localparam int BackLuts = lutCount(Lookback, LutSize);

    // Taps base..base+LutSize-1 from hb or hf with zeros past the table end
    function automatic acc_t [LutSize-1:0] coeffSlice(input logic ahead, input int base);
        acc_t [LutSize-1:0] slice;
        for (int k = 0; k < LutSize; k++) begin
            if (base + k >= MaxTaps) begin
                slice[k] = '0;
            end else if (ahead) begin
                slice[k] = hb[base+k];
            end else begin
                slice[k] = hf[base+k];
            end
        end
        return slice;
    endfunction

    for (genvar s = 0; s < AheadLuts; s++) begin : genAhead
        localparam int Base = s * LutSize;
        localparam int Width = (Lookahead - Base < LutSize) ? Lookahead - Base : LutSize;
        localparam acc_t [LutSize-1:0] Slice = coeffSlice(1'b1, Base);
        DaLut #(.Size(Width), .Coeffs(Slice[Width-1:0])) uLut (
            .sel    (aheadBits[Base +: Width]),
            .result (lutSums[s])
        );
    end

    // Lookback tables follow the lookahead ones
    for (genvar s = 0; s < BackLuts; s++) begin : genBack
        localparam int Base = s * LutSize;
        localparam int Width = (Lookback - Base < LutSize) ? Lookback - Base : LutSize;
        localparam acc_t [LutSize-1:0] Slice = coeffSlice(1'b0, Base);
        DaLut #(.Size(Width), .Coeffs(Slice[Width-1:0])) uLut (
            .sel    (backBits[Base +: Width]),
            .result (lutSums[AheadLuts+s])
        );
    end

endmodule

// ==== src/AdderTree.sv ====
`timescale 1ns/100ps

module AdderTree import FirTypesPkg::*; #(
    parameter int NumLuts = 4
) (
    input  logic               clkDS,
    input  logic               rst,
    input  acc_t [NumLuts-1:0] lutSums,
    input  logic               inValid,
    output treeBeat_t          beatOut
);

    localparam int AdderLayers = $clog2(NumLuts);

    // Number of elements at a tree level counted from the LUTs at level 0
    function automatic int nodeCount(input int level);
        int n;
        n = NumLuts;
        for (int k = 0; k < level; k++) begin
            n = (n + 1) / 2;
        end
        return n;
    endfunction

    for (genvar l = 0; l < AdderLayers; l++) begin : genLayer
        localparam int InCnt = nodeCount(l);
        localparam int OutCnt = nodeCount(l + 1);

        treeBeat_t [InCnt-1:0]  src;
        treeBeat_t [OutCnt-1:0] nxt;
        treeBeat_t [OutCnt-1:0] beats;

        if (l == 0) begin : genFirst
            // Tag each LUT result with the window state
            for (genvar n = 0; n < InCnt; n++) begin : genTag
                assign src[n].sum = lutSums[n];
                assign src[n].valid = inValid;
            end
        end else begin : genNext
            assign src = genLayer[l-1].beats;
        end

        for (genvar n = 0; n < OutCnt; n++) begin : genNode
            if (2 * n + 1 < InCnt) begin : genAdd
                assign nxt[n].sum = src[2*n].sum + src[2*n+1].sum;
                assign nxt[n].valid = src[2*n].valid & src[2*n+1].valid;
            end else begin : genPass
                // Odd leftover is only delayed
                assign nxt[n] = src[2*n];
            end
        end

        always_ff @(posedge clkDS) begin
            if (!rst) begin
                beats <= '0;
            end else begin
                beats <= nxt;
            end
        end
    end

    assign beatOut = genLayer[AdderLayers-1].beats[0];

endmodule

// ==== src/FirOutputStage.sv ====
`timescale 1ns/100ps

module FirOutputStage import FirTypesPkg::*; (
    input  logic      clkDS,
    input  logic      rst,
    input  treeBeat_t beatIn,
    output out_t      out,
    output logic      valid
);

    // Drop the fraction bits that do not fit the output word
    localparam int Shift = MantW - (OutW - 1);
    localparam acc_t MaxOut = acc_t'(2 ** (OutW - 1) - 1);
    localparam acc_t MinOut = acc_t'(-(2 ** (OutW - 1)));

    acc_t                   scaled;
    logic signed [OutW-1:0] clipped;
    out_t                   offsetWord;

    always_comb begin
        scaled = beatIn.sum >>> Shift;
        if (scaled > MaxOut) begin
            clipped = MaxOut[OutW-1:0];
        end else if (scaled < MinOut) begin
            clipped = MinOut[OutW-1:0];
        end else begin
            clipped = scaled[OutW-1:0];
        end
        // Two's complement to offset binary
        offsetWord = {~clipped[OutW-1], clipped[OutW-2:0]};
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            out <= '0;
            valid <= 1'b0;
        end else begin
            out <= offsetWord;
            valid <= beatIn.valid;
        end
    end

endmodule

// ==== src/FirDecimatorTop.sv ====
`timescale 1ns/100ps

module FirDecimatorTop import FirTypesPkg::*; #(
    parameter int Osr = 4,
    parameter int Lookahead = 8,
    parameter int Lookback = 8,
    parameter int LutSize = 4
) (
    input  logic           clkDS,
    input  logic           rst,
    input  logic [Osr-1:0] frame,
    output out_t           out,
    output logic           valid
);

    localparam int NumLuts = lutCount(Lookahead, LutSize) + lutCount(Lookback, LutSize);

    logic [Lookahead-1:0] aheadBits;
    logic [Lookback-1:0]  backBits;
    logic                 windowFull;
    acc_t [NumLuts-1:0]   lutSums;
    treeBeat_t            treeOut;

    SampleWindow #(.Osr(Osr), .Lookahead(Lookahead), .Lookback(Lookback)) uWindow (
        .clkDS      (clkDS),
        .rst        (rst),
        .frame      (frame),
        .aheadBits  (aheadBits),
        .backBits   (backBits),
        .windowFull (windowFull)
    );

    LutBank #(
        .Lookahead (Lookahead),
        .Lookback  (Lookback),
        .LutSize   (LutSize),
        .NumLuts   (NumLuts)
    ) uLuts (
        .aheadBits (aheadBits),
        .backBits  (backBits),
        .lutSums   (lutSums)
    );

    AdderTree #(.NumLuts(NumLuts)) uTree (
        .clkDS   (clkDS),
        .rst     (rst),
        .lutSums (lutSums),
        .inValid (windowFull),
        .beatOut (treeOut)
    );

    FirOutputStage uOutput (
        .clkDS  (clkDS),
        .rst    (rst),
        .beatIn (treeOut),
        .out    (out),
        .valid  (valid)
    );

endmodule

// ==== tests/FirDecimatorTb.sv ====
`timescale 1ns/100ps

module FirDecimatorTb import FirTypesPkg::*, FirCoeffPkg::*; ();

    // Mirrors the default DUT parameters
    localparam int Osr = 4;
    localparam int Lookahead = 8;
    localparam int Lookback = 8;
    localparam int LutSize = 4;
    localparam int Total = Lookahead + Lookback;
    localparam int FillFrames = (Total + Osr - 1) / Osr;
    localparam int NumLuts = (Lookahead + LutSize - 1) / LutSize
                           + (Lookback + LutSize - 1) / LutSize;
    // Adder layers plus the output register
    localparam int Latency = $clog2(NumLuts) + 1;
    localparam int Shift = MantW - (OutW - 1);

    localparam int ClkPeriod = 10;
    localparam int ResetCycles = 5;
    localparam int ZeroFrames = 12;
    localparam int RandomFrames = 400;
    localparam int SatFrames = 8;
    localparam int MidResetCycles = 3;
    localparam int Drain = FillFrames + Latency;
    localparam int TestCycles = ResetCycles + ZeroFrames + Osr * (Drain + 1) + RandomFrames
                              + MidResetCycles + SatFrames + Drain;
    localparam int WatchdogCycles = TestCycles * 3 / 2 + 100;

    logic           clkDS;
    logic           rst;
    logic [Osr-1:0] frame;
    out_t           out;
    logic           valid;

    // Reference model state
    logic [Total-1:0] history;
    int               framesSeen;
    int               sinceReset;
    out_t             pipeWord [Latency];
    logic             pipeValid [Latency];
    logic             checkEn = 1'b0;

    int          outErrors = 0;
    int          validErrors = 0;
    int          warmErrors = 0;
    string       testName;

    FirDecimatorTop UUT (
        .clkDS (clkDS),
        .rst   (rst),
        .frame (frame),
        .out   (out),
        .valid (valid)
    );

    initial begin
        clkDS = 1'b0;
        forever #(ClkPeriod / 2) clkDS = ~clkDS;
    end

    // Filter rule applied to a bit history whose index 0 is the newest sample
    function automatic out_t filterWord(input logic [Total-1:0] hist);
        int sum;
        int scaled;
        int maxOut;
        int tap;
        maxOut = 2 ** (OutW - 1) - 1;
        sum = 0;
        for (int a = 0; a < Total; a++) begin
            // Youngest samples meet the lookahead taps back to front
            if (a < Lookahead) begin
                tap = int'(hb[Lookahead-1-a]);
            end else begin
                tap = int'(hf[a-Lookahead]);
            end
            if (hist[a]) begin
                sum += tap;
            end
        end
        scaled = sum >>> Shift;
        if (scaled > maxOut) begin
            scaled = maxOut;
        end else if (scaled < -maxOut - 1) begin
            scaled = -maxOut - 1;
        end
        return out_t'(scaled + maxOut + 1);
    endfunction

    always @(posedge clkDS) begin
        if (!rst) begin
            history = '0;
            framesSeen = 0;
            sinceReset = 0;
            // Cleared tree beats still turn into midscale words
            for (int k = 0; k < Latency - 1; k++) begin
                pipeWord[k] = filterWord('0);
                pipeValid[k] = 1'b0;
            end
            pipeWord[Latency-1] = '0;
            pipeValid[Latency-1] = 1'b0;
            checkEn = 1'b1;
        end else begin
            for (int k = Latency - 1; k > 0; k--) begin
                pipeWord[k] = pipeWord[k-1];
                pipeValid[k] = pipeValid[k-1];
            end
            pipeWord[0] = filterWord(history);
            pipeValid[0] = (framesSeen >= FillFrames);
            history = Total'({history, frame});
            if (framesSeen < FillFrames) begin
                framesSeen++;
            end
            if (sinceReset < FillFrames + Latency) begin
                sinceReset++;
            end
        end
    end

    // Outputs settle well before the falling edge
    outMatch: assert property (@(negedge clkDS) disable iff (!checkEn)
        out == pipeWord[Latency-1])
        else begin
            outErrors++;
            $display("error %s: out expected %0d actual %0d",
                     testName, pipeWord[Latency-1], out);
        end

    validMatch: assert property (@(negedge clkDS) disable iff (!checkEn)
        valid == pipeValid[Latency-1])
        else begin
            validErrors++;
            $display("error %s: valid expected %0b actual %0b",
                     testName, pipeValid[Latency-1], valid);
        end

    warmUpTiming: assert property (@(negedge clkDS) disable iff (!checkEn)
        valid == (sinceReset >= FillFrames + Latency))
        else begin
            warmErrors++;
            $display("error %s: valid expected %0b actual %0b at %0d edges after reset",
                     testName, sinceReset >= FillFrames + Latency, valid, sinceReset);
        end

    task automatic sendFrame(input logic [Osr-1:0] value);
        @(negedge clkDS);
        frame = value;
    endtask

    task automatic applyReset(input int cycles);
        @(negedge clkDS);
        rst = 1'b0;
        repeat (cycles) @(negedge clkDS);
        rst = 1'b1;
    endtask

    task automatic reportCounts();
        $display("out errors: %0d, valid errors: %0d, warm-up errors: %0d",
                 outErrors, validErrors, warmErrors);
    endtask

    initial begin
        void'($urandom(87));
        rst = 1'b0;
        frame = '0;
        testName = "reset";
        repeat (ResetCycles) @(posedge clkDS);
        @(negedge clkDS);
        rst = 1'b1;

        testName = "zero input";
        repeat (ZeroFrames) sendFrame('0);

        // One bit per frame position reaches every tap
        testName = "impulse";
        for (int p = 0; p < Osr; p++) begin
            sendFrame(Osr'(1) << p);
            repeat (Drain) sendFrame('0);
        end

        testName = "random";
        repeat (RandomFrames / 2) sendFrame(Osr'($urandom));
        testName = "mid-run reset";
        applyReset(MidResetCycles);
        testName = "random after reset";
        repeat (RandomFrames / 2) sendFrame(Osr'($urandom));

        testName = "saturation";
        repeat (SatFrames) sendFrame('1);
        testName = "drain";
        repeat (Drain) sendFrame('0);
        @(negedge clkDS);
        @(posedge clkDS);

        reportCounts();
        if (outErrors + validErrors + warmErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles, the tests did not complete",
                 WatchdogCycles);
        reportCounts();
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== files.f ====
src/FirTypesPkg.sv
src/FirCoeffPkg.sv
src/SampleWindow.sv
src/DaLut.sv
src/LutBank.sv
src/AdderTree.sv
src/FirOutputStage.sv
src/FirDecimatorTop.sv
tests/FirDecimatorTb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module FirDecimatorTb \
    -f files.f -Mdir obj_dir -o simFir

./obj_dir/simFir > sim.log
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
